// File: hw/vector_lsu.sv
`timescale 1ns/1ps
`default_nettype none

module vector_lsu
    import vlsu_pkg::*;
(
    input  wire logic         clk,
    input  wire logic         reset_n,
    input  wire logic         start_i,
    input  vlsu_cmd_t         cmd_i,
    output logic              busy_o,
    output logic              done_o,
    output logic [VLEN-1:0]   rdata_o,
    output mem_req_t          mem_req_o,
    input  mem_word_u         mem_rdata_i
);

    vlsu_cmd_t        cmd_q;
    logic [VL_W-1:0]  elems_per_beat;
    logic             idle;
    logic             issue;
    logic             clear;
    logic [VL_W-1:0]  elem_idx;
    beat_t            beat;

    vlsu_cmd_reg vlsu_cmd_reg_inst (
        .clk              (clk),
        .reset_n          (reset_n),
        .start_i          (start_i),
        .idle_i           (idle),
        .cmd_i            (cmd_i),
        .cmd_o            (cmd_q),
        .elems_per_beat_o (elems_per_beat)
    );

    vlsu_ctrl vlsu_ctrl_inst (
        .clk              (clk),
        .reset_n          (reset_n),
        .start_i          (start_i),
        .cmd_i            (cmd_q),
        .elems_per_beat_i (elems_per_beat),
        .idle_o           (idle),
        .issue_o          (issue),
        .clear_o          (clear),
        .elem_idx_o       (elem_idx),
        .busy_o           (busy_o),
        .done_o           (done_o)
    );

    // Stage 1, request out in the issue cycle
    vlsu_addr_gen vlsu_addr_gen_inst (
        .clk        (clk),
        .reset_n    (reset_n),
        .cmd_i      (cmd_q),
        .issue_i    (issue),
        .elem_idx_i (elem_idx),
        .mem_req_o  (mem_req_o),
        .beat_o     (beat)
    );

    // Stage 2, merge of the returned word
    vlsu_load_align vlsu_load_align_inst (
        .clk         (clk),
        .reset_n     (reset_n),
        .clear_i     (clear),
        .cmd_i       (cmd_q),
        .beat_i      (beat),
        .mem_rdata_i (mem_rdata_i),
        .rdata_o     (rdata_o)
    );

endmodule

`default_nettype wire

// File: hw/vlsu_addr_gen.sv
`timescale 1ns/1ps
`default_nettype none

module vlsu_addr_gen
    import vlsu_pkg::*;
(
    input  wire logic             clk,
    input  wire logic             reset_n,
    input  vlsu_cmd_t             cmd_i,
    input  wire logic             issue_i,
    input  wire logic [VL_W-1:0]  elem_idx_i,
    output mem_req_t              mem_req_o,
    output beat_t                 beat_o
);

    logic [31:0]               offset_q;
    logic [31:0]               step;
    logic [31:0]               addr;
    logic [3:0]                lanes;
    logic [31:0]               beat_wdata;
    logic [VL_W-1:0]           lane_idx;
    logic                      cur_active;
    logic [VLENB-1:0][7:0]     wdata_b;
    logic [VLENB/2-1:0][15:0]  wdata_h;
    logic [VLENB/4-1:0][31:0]  wdata_w;

    // Inside vl and not masked off
    function automatic logic elem_active(input vlsu_cmd_t cmd, input logic [VL_W-1:0] idx);
        return (idx < cmd.vl) && (cmd.vm || cmd.mask[idx[EIDX8_W-1:0]]);
    endfunction

    ///////////////////////////////////////////////////////////////////////
    // Address
    ///////////////////////////////////////////////////////////////////////

    assign step = (cmd_i.mode == UNIT_STRIDED) ? 32'd4 : cmd_i.stride;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            offset_q <= '0;
        end else if (issue_i) begin
            offset_q <= offset_q + step;
        end else begin
            offset_q <= '0;
        end
    end

    assign addr = cmd_i.base + offset_q;

    ///////////////////////////////////////////////////////////////////////
    // Byte lanes and store data
    ///////////////////////////////////////////////////////////////////////

    assign wdata_b    = cmd_i.wdata;
    assign wdata_h    = cmd_i.wdata;
    assign wdata_w    = cmd_i.wdata;
    assign cur_active = elem_active(cmd_i, elem_idx_i);

    always_comb begin
        lanes      = 4'b0000;
        beat_wdata = '0;
        lane_idx   = elem_idx_i;
        if (cmd_i.mode == UNIT_STRIDED) begin
            // Packed elements, element j sits at lane j * bytes
            case (cmd_i.width)
                EW8: begin
                    for (int j = 0; j < 4; j++) begin
                        lane_idx             = elem_idx_i + VL_W'(j);
                        lanes[j]             = elem_active(cmd_i, lane_idx);
                        beat_wdata[8*j +: 8] = wdata_b[lane_idx[EIDX8_W-1:0]];
                    end
                end
                EW16: begin
                    for (int j = 0; j < 2; j++) begin
                        lane_idx               = elem_idx_i + VL_W'(j);
                        lanes[2*j +: 2]        = {2{elem_active(cmd_i, lane_idx)}};
                        beat_wdata[16*j +: 16] = wdata_h[lane_idx[EIDX16_W-1:0]];
                    end
                end
                default: begin
                    lanes      = {4{cur_active}};
                    beat_wdata = wdata_w[elem_idx_i[EIDX32_W-1:0]];
                end
            endcase
        end else begin
            // One element, lanes from the low address bits
            case (cmd_i.width)
                EW8: begin
                    lanes      = cur_active ? (4'b0001 << addr[1:0]) : 4'b0000;
                    beat_wdata = {4{wdata_b[elem_idx_i[EIDX8_W-1:0]]}};
                end
                EW16: begin
                    if (cur_active) begin
                        lanes = addr[1] ? 4'b1100 : 4'b0011;
                    end
                    beat_wdata = {2{wdata_h[elem_idx_i[EIDX16_W-1:0]]}};
                end
                default: begin
                    lanes      = {4{cur_active}};
                    beat_wdata = wdata_w[elem_idx_i[EIDX32_W-1:0]];
                end
            endcase
        end
    end

    assign mem_req_o.addr  = addr;
    assign mem_req_o.we    = lanes & {4{issue_i && (cmd_i.op == VSTORE)}};
    assign mem_req_o.wdata = beat_wdata;

    assign beat_o.elem_idx = elem_idx_i;
    assign beat_o.lanes    = lanes;
    assign beat_o.valid    = issue_i;

endmodule

`default_nettype wire

// File: hw/vlsu_cmd_reg.sv
`timescale 1ns/1ps
`default_nettype none

module vlsu_cmd_reg
    import vlsu_pkg::*;
(
    input  wire logic            clk,
    input  wire logic            reset_n,
    input  wire logic            start_i,
    input  wire logic            idle_i,
    input  vlsu_cmd_t            cmd_i,
    output vlsu_cmd_t            cmd_o,
    output logic [VL_W-1:0]      elems_per_beat_o
);

    vlsu_cmd_t cmd_d;
    vlsu_cmd_t cmd_q;

    // Unit-strided bases are taken as word aligned
    always_comb begin
        cmd_d = cmd_i;
        if (cmd_i.mode == UNIT_STRIDED) begin
            cmd_d.base[1:0] = 2'b00;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cmd_q <= '0;
        end else if (start_i && idle_i) begin
            cmd_q <= cmd_d;
        end
    end

    assign cmd_o = cmd_q;

    ///////////////////////////////////////////////////////////////////////
    // Elements moved per beat
    ///////////////////////////////////////////////////////////////////////

    always_comb begin
        if (cmd_q.mode == STRIDED) begin
            elems_per_beat_o = VL_W'(1);
        end else begin
            case (cmd_q.width)
                EW8:     elems_per_beat_o = VL_W'(4);
                EW16:    elems_per_beat_o = VL_W'(2);
                default: elems_per_beat_o = VL_W'(1);
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/vlsu_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module vlsu_ctrl
    import vlsu_pkg::*;
(
    input  wire logic             clk,
    input  wire logic             reset_n,
    input  wire logic             start_i,
    input  vlsu_cmd_t             cmd_i,
    input  wire logic [VL_W-1:0]  elems_per_beat_i,
    output logic                  idle_o,
    output logic                  issue_o,
    output logic                  clear_o,
    output logic [VL_W-1:0]       elem_idx_o,
    output logic                  busy_o,
    output logic                  done_o
);

    vlsu_state_e      state_q;
    vlsu_state_e      state_d;
    logic [VL_W-1:0]  idx_q;
    logic [VL_W-1:0]  idx_next;
    logic             accept;
    logic             last_beat;
    logic             done_q;

    assign accept    = start_i && (state_q == ST_IDLE);
    assign idx_next  = idx_q + elems_per_beat_i;
    // This beat covers the final active element
    assign last_beat = (idx_next >= cmd_i.vl);

    ///////////////////////////////////////////////////////////////////////
    // FSM
    ///////////////////////////////////////////////////////////////////////

    always_comb begin
        case (state_q)
            ST_IDLE:  state_d = accept ? ST_ISSUE : ST_IDLE;
            ST_ISSUE: state_d = last_beat ? ST_DRAIN : ST_ISSUE;
            ST_DRAIN: state_d = ST_IDLE;
            default:  state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q <= ST_IDLE;
            idx_q   <= '0;
            done_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            done_q  <= (state_q == ST_DRAIN);
            // Counter restarts from zero for the next command
            if (state_q == ST_ISSUE && !last_beat) begin
                idx_q <= idx_next;
            end else begin
                idx_q <= '0;
            end
        end
    end

    assign idle_o     = (state_q == ST_IDLE);
    assign issue_o    = (state_q == ST_ISSUE);
    assign clear_o    = accept;
    assign elem_idx_o = idx_q;
    assign busy_o     = (state_q != ST_IDLE);
    assign done_o     = done_q;

endmodule

`default_nettype wire

// File: hw/vlsu_load_align.sv
`timescale 1ns/1ps
`default_nettype none

module vlsu_load_align
    import vlsu_pkg::*;
(
    input  wire logic         clk,
    input  wire logic         reset_n,
    input  wire logic         clear_i,
    input  vlsu_cmd_t         cmd_i,
    input  beat_t             beat_i,
    input  mem_word_u         mem_rdata_i,
    output logic [VLEN-1:0]   rdata_o
);

    beat_t                     beat_q;
    logic [VLEN-1:0]           rdata_q;
    logic [VLEN-1:0]           rdata_d;
    logic [VLENB-1:0][7:0]     res_b;
    logic [VLENB/2-1:0][15:0]  res_h;
    logic [VLENB/4-1:0][31:0]  res_w;
    logic [VL_W-1:0]           lane_idx;
    logic [1:0]                byte_sel;
    logic                      merge;

    // Stage barrier, read data for this beat arrives next cycle
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            beat_q <= '0;
        end else begin
            beat_q <= beat_i;
        end
    end

    assign merge = beat_q.valid && (cmd_i.op == VLOAD);

    // Strided byte loads have a single lane set
    always_comb begin
        byte_sel = 2'd0;
        for (int k = 0; k < 4; k++) begin
            if (beat_q.lanes[k]) begin
                byte_sel = 2'(k);
            end
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // Lane merge
    ///////////////////////////////////////////////////////////////////////

    always_comb begin
        res_b    = rdata_q;
        res_h    = rdata_q;
        res_w    = rdata_q;
        rdata_d  = rdata_q;
        lane_idx = beat_q.elem_idx;
        case (cmd_i.width)
            EW8: begin
                if (cmd_i.mode == UNIT_STRIDED) begin
                    for (int j = 0; j < 4; j++) begin
                        lane_idx = beat_q.elem_idx + VL_W'(j);
                        if (beat_q.lanes[j]) begin
                            res_b[lane_idx[EIDX8_W-1:0]] = mem_rdata_i.b[j];
                        end
                    end
                end else if (|beat_q.lanes) begin
                    res_b[beat_q.elem_idx[EIDX8_W-1:0]] = mem_rdata_i.b[byte_sel];
                end
                rdata_d = res_b;
            end
            EW16: begin
                if (cmd_i.mode == UNIT_STRIDED) begin
                    for (int j = 0; j < 2; j++) begin
                        lane_idx = beat_q.elem_idx + VL_W'(j);
                        if (beat_q.lanes[2*j]) begin
                            res_h[lane_idx[EIDX16_W-1:0]] = mem_rdata_i.h[j];
                        end
                    end
                end else if (|beat_q.lanes) begin
                    res_h[beat_q.elem_idx[EIDX16_W-1:0]] = mem_rdata_i.h[beat_q.lanes[2]];
                end
                rdata_d = res_h;
            end
            EW32: begin
                if (beat_q.lanes[0]) begin
                    res_w[beat_q.elem_idx[EIDX32_W-1:0]] = mem_rdata_i;
                end
                rdata_d = res_w;
            end
            default: rdata_d = rdata_q;
        endcase
    end

    // Inactive and tail elements keep the zero from start
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rdata_q <= '0;
        end else if (clear_i) begin
            rdata_q <= '0;
        end else if (merge) begin
            rdata_q <= rdata_d;
        end
    end

    assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: hw/vlsu_pkg.sv
`default_nettype none

package vlsu_pkg;

    ///////////////////////////////////////////////////////////////////////
    // Sizes
    ///////////////////////////////////////////////////////////////////////

    localparam int VLEN     = 128;
    localparam int VLENB    = VLEN / 8;
    localparam int VL_W     = 5;

    // Element index widths per element size inside one register
    localparam int EIDX8_W  = $clog2(VLENB);
    localparam int EIDX16_W = $clog2(VLENB / 2);
    localparam int EIDX32_W = $clog2(VLENB / 4);

    ///////////////////////////////////////////////////////////////////////
    // Encodings
    ///////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        EW8  = 2'd0,
        EW16 = 2'd1,
        EW32 = 2'd2
    } vew_e;

    typedef enum logic {
        UNIT_STRIDED = 1'b0,
        STRIDED      = 1'b1
    } addr_mode_e;

    typedef enum logic {
        VLOAD  = 1'b0,
        VSTORE = 1'b1
    } vlsu_op_e;

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_ISSUE = 2'd1,
        ST_DRAIN = 2'd2
    } vlsu_state_e;

    ///////////////////////////////////////////////////////////////////////
    // Bundles
    ///////////////////////////////////////////////////////////////////////

    typedef struct packed {
        vlsu_op_e          op;
        addr_mode_e        mode;
        vew_e              width;
        logic [31:0]       base;
        logic [31:0]       stride;
        logic [VL_W-1:0]   vl;
        logic              vm;
        logic [VLENB-1:0]  mask;
        logic [VLEN-1:0]   wdata;
    } vlsu_cmd_t;

    typedef struct packed {
        logic [31:0]       addr;
        logic [3:0]        we;
        logic [31:0]       wdata;
    } mem_req_t;

    // One beat in flight between address and load stages
    typedef struct packed {
        logic [VL_W-1:0]   elem_idx;
        logic [3:0]        lanes;
        logic              valid;
    } beat_t;

    // Read word, seen as bytes or halfwords by the load path
    typedef union packed {
        logic [3:0][7:0]   b;
        logic [1:0][15:0]  h;
    } mem_word_u;

endpackage

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Compile with Verilator, run, and decide on the log contents
rm -f sim.log &&
verilator --binary --timing --timescale 1ns/1ps --top-module tb_vector_lsu -f vector_lsu.f &&
./obj_dir/Vtb_vector_lsu 2>&1 | tee sim.log
grep -q "^Verification passed$" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }

// File: sim/tb_vector_lsu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_vector_lsu
    import vlsu_pkg::*;
();

    localparam int          NUM_CMDS       = 200;
    localparam int          MEM_WORDS      = 256;
    localparam int          TIMEOUT_CYCLES = NUM_CMDS * (VLENB + 4) + 200;
    localparam logic [15:0] LFSR_SEED      = 16'd26884;

    logic             clk;
    logic             reset_n;
    logic             start_i;
    vlsu_cmd_t        cmd_i;
    logic             busy_o;
    logic             done_o;
    logic [VLEN-1:0]  rdata_o;
    mem_req_t         mem_req_o;
    mem_word_u        rd_word = '0;

    mem_word_u        mem [MEM_WORDS];
    mem_word_u        mem_image [MEM_WORDS];
    mem_word_u        shadow [MEM_WORDS];
    logic [15:0]      lfsr_state;
    int               cycle_count = 0;

    vector_lsu vector_lsu_inst (
        .clk         (clk),
        .reset_n     (reset_n),
        .start_i     (start_i),
        .cmd_i       (cmd_i),
        .busy_o      (busy_o),
        .done_o      (done_o),
        .rdata_o     (rdata_o),
        .mem_req_o   (mem_req_o),
        .mem_rdata_i (rd_word)
    );

    always #5 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // Memory model with one beat per cycle and read data one cycle later
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (!reset_n) begin
            for (int w = 0; w < MEM_WORDS; w++) begin
                mem[8'(w)] <= mem_image[8'(w)];
            end
            rd_word <= '0;
        end else begin
            rd_word <= mem[mem_req_o.addr[9:2]];
            for (int k = 0; k < 4; k++) begin
                if (mem_req_o.we[k]) begin
                    mem[mem_req_o.addr[9:2]].b[2'(k)] <= mem_req_o.wdata[5'(8 * k) +: 8];
                end
            end
        end
    end

    // Watchdog
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("Verification failed");
            $fatal(1, "watchdog expired");
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Random source
    //////////////////////////////////////////////////////////////////////

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] val;
        val = '0;
        for (int k = 0; k < count; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
        return val;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    function automatic int bytes_of(input vew_e width);
        case (width)
            EW8:     return 1;
            EW16:    return 2;
            default: return 4;
        endcase
    endfunction

    function automatic int beats_of(input vlsu_cmd_t cmd);
        int epb;
        epb = (cmd.mode == STRIDED) ? 1 : 4 / bytes_of(cmd.width);
        return (int'(cmd.vl) + epb - 1) / epb;
    endfunction

    // Word that holds element i within the 1 KiB memory
    function automatic logic [7:0] word_index(input vlsu_cmd_t cmd, input int i);
        logic [31:0] a;
        if (cmd.mode == UNIT_STRIDED) begin
            a = cmd.base + 32'(4 * (i / (4 / bytes_of(cmd.width))));
        end else begin
            a = cmd.base + 32'(i) * cmd.stride;
        end
        return a[9:2];
    endfunction

    function automatic int first_lane(input vlsu_cmd_t cmd, input int i);
        logic [31:0] a;
        int nbytes;
        nbytes = bytes_of(cmd.width);
        a = cmd.base + 32'(i) * cmd.stride;
        if (cmd.mode == UNIT_STRIDED) begin
            return (i % (4 / nbytes)) * nbytes;
        end
        return int'(a[1:0]);
    endfunction

    function automatic logic [VLEN-1:0] predict_load(input vlsu_cmd_t cmd);
        logic [VLEN-1:0] res;
        logic [7:0]      wi;
        int              nbytes;
        int              lane;
        res = '0;
        nbytes = bytes_of(cmd.width);
        for (int i = 0; i < int'(cmd.vl); i++) begin
            if (cmd.vm || cmd.mask[4'(i)]) begin
                wi = word_index(cmd, i);
                lane = first_lane(cmd, i);
                for (int b = 0; b < nbytes; b++) begin
                    res[7'((i * nbytes + b) * 8) +: 8] = shadow[wi].b[2'(lane + b)];
                end
            end
        end
        return res;
    endfunction

    task automatic apply_store(input vlsu_cmd_t cmd);
        logic [7:0] wi;
        int         nbytes;
        int         lane;
        nbytes = bytes_of(cmd.width);
        for (int i = 0; i < int'(cmd.vl); i++) begin
            if (cmd.vm || cmd.mask[4'(i)]) begin
                wi = word_index(cmd, i);
                lane = first_lane(cmd, i);
                for (int b = 0; b < nbytes; b++) begin
                    shadow[wi].b[2'(lane + b)] = cmd.wdata[7'((i * nbytes + b) * 8) +: 8];
                end
            end
        end
    endtask

    function automatic vlsu_cmd_t build_cmd();
        vlsu_cmd_t   cmd;
        logic [31:0] r;
        int          nbytes;
        cmd = '0;
        r = take_bits(1);
        cmd.op = vlsu_op_e'(r[0]);
        r = take_bits(1);
        cmd.mode = addr_mode_e'(r[0]);
        r = take_bits(2) % 3;
        cmd.width = vew_e'(r[1:0]);
        nbytes = bytes_of(cmd.width);
        r = take_bits(5) % 32'(VLENB / nbytes);
        cmd.vl = VL_W'(r + 1);
        r = take_bits(1);
        cmd.vm = r[0];
        r = take_bits(16);
        cmd.mask = r[15:0];
        // Unit-strided ignores the two low base bits
        cmd.base = take_bits(10);
        if (cmd.mode == STRIDED) begin
            cmd.base = cmd.base & ~32'(nbytes - 1);
        end
        cmd.stride = take_bits(5) * 32'(nbytes);
        for (int k = 0; k < VLENB / 4; k++) begin
            cmd.wdata[7'(32 * k) +: 32] = take_bits(32);
        end
        return cmd;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    task automatic vec_compare(input string name, input logic [VLEN-1:0] got,
                               input logic [VLEN-1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
            $display("Verification failed");
            $fatal(1, "result mismatch");
        end
    endtask

    task automatic memword_compare(input string name, input mem_word_u got,
                                   input mem_word_u exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
            $display("Verification failed");
            $fatal(1, "memory mismatch");
        end
    endtask

    task automatic flag_compare(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
            $display("Verification failed");
            $fatal(1, "flag mismatch");
        end
    endtask

    task automatic memory_compare();
        for (int w = 0; w < MEM_WORDS; w++) begin
            memword_compare($sformatf("mem[%0d]", w), mem[8'(w)], shadow[8'(w)]);
        end
    endtask

    task automatic idle_outputs_check();
        flag_compare("busy_o", busy_o, 1'b0);
        flag_compare("done_o", done_o, 1'b0);
        flag_compare("mem_req_o.we", |mem_req_o.we, 1'b0);
        vec_compare("rdata_o", rdata_o, '0);
    endtask

    // Checks one command cycle by cycle against the fixed pipeline timing
    task automatic run_command(input vlsu_cmd_t cmd, input vlsu_cmd_t junk,
                               input logic extra_start);
        int              n_beats;
        logic [VLEN-1:0] exp_rdata;
        n_beats = beats_of(cmd);
        exp_rdata = (cmd.op == VLOAD) ? predict_load(cmd) : '0;
        @(posedge clk);
        start_i <= 1'b1;
        cmd_i   <= cmd;
        for (int cyc = 0; cyc <= n_beats + 2; cyc++) begin
            if (cyc > 0) begin
                @(posedge clk);
            end
            // Second strobe arrives while busy and must be ignored
            if (cyc == 1) begin
                start_i <= extra_start;
                cmd_i   <= junk;
            end else if (cyc == 2) begin
                start_i <= 1'b0;
            end
            @(negedge clk);
            flag_compare("busy_o", busy_o, (cyc >= 1) && (cyc <= n_beats + 1));
            flag_compare("done_o", done_o, cyc == n_beats + 2);
            if (cmd.op == VLOAD) begin
                flag_compare("mem_req_o.we", |mem_req_o.we, 1'b0);
            end
        end
        if (cmd.op == VSTORE) begin
            apply_store(cmd);
        end
        vec_compare("rdata_o", rdata_o, exp_rdata);
        memory_compare();
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        vlsu_cmd_t   cmd;
        vlsu_cmd_t   junk;
        logic [31:0] r;
        clk        = 1'b0;
        reset_n    = 1'b0;
        start_i    = 1'b0;
        cmd_i      = '0;
        lfsr_state = LFSR_SEED;
        for (int w = 0; w < MEM_WORDS; w++) begin
            mem_image[8'(w)] = take_bits(32);
            shadow[8'(w)]    = mem_image[8'(w)];
        end
        repeat (10) begin
            @(negedge clk);
            idle_outputs_check();
        end
        @(posedge clk);
        reset_n <= 1'b1;
        @(negedge clk);
        idle_outputs_check();
        for (int n = 0; n < NUM_CMDS; n++) begin
            cmd  = build_cmd();
            junk = build_cmd();
            r    = take_bits(1);
            run_command(cmd, junk, r[0]);
        end
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: vector_lsu.f
hw/vlsu_pkg.sv
hw/vlsu_cmd_reg.sv
hw/vlsu_ctrl.sv
hw/vlsu_addr_gen.sv
hw/vlsu_load_align.sv
hw/vector_lsu.sv
sim/tb_vector_lsu.sv
